//--- source/dd_loader_pkg.sv
// ======================================================================
// Shared definitions of the ROM download path
// Region base addresses, SDRAM bank offsets and PROM bank count
// Vector typedefs and the SDRAM writer state encoding
// ======================================================================

package dd_loader_pkg;

    // Download byte address and payload
    typedef logic [21:0] dl_addr_t;
    typedef logic [7:0]  byte_t;

    // Active low, bit 0 is the low byte of the word
    typedef logic [1:0]  word_mask_t;

    // PROM bank addressing
    typedef logic [7:0]  prom_addr_t;

    // Region bases in the download stream
    localparam dl_addr_t main_base   = 22'h000000;
    localparam dl_addr_t adpcm_base  = 22'h030000;
    localparam dl_addr_t char_base   = 22'h050000;
    localparam dl_addr_t scr_zw_base = 22'h060000;
    localparam dl_addr_t scr_xy_base = 22'h080000;
    localparam dl_addr_t obj_wz_base = 22'h0A0000;
    localparam dl_addr_t obj_xy_base = 22'h0E0000;
    localparam dl_addr_t mcu_base    = 22'h120000;
    localparam dl_addr_t prom_base   = 22'h124000;

    // MCU code lands here in SDRAM word space
    localparam dl_addr_t mcu_word_base = 22'h018000;

    // SDRAM 64K-word block offsets for the graphics
    localparam logic [4:0] scr_bank = 5'd6;
    localparam logic [4:0] obj_bank = 5'd8;

    // On-chip PROM row
    localparam int prom_count = 4;

    typedef logic [1:0]            prom_sel_t;
    typedef logic [prom_count-1:0] prom_we_t;

    // SDRAM writer FSM
    typedef enum logic [1:0] {
        idle,
        write,
        ack
    } wr_state_t;

endpackage

//--- source/dd_rom_mapper.sv
// ======================================================================
// Download address mapper
// Sorts loader bytes into SDRAM word writes or PROM bank writes
// Rearranges graphics addresses into the video fetch layout
// ======================================================================

`timescale 1ns/1ns

module dd_rom_mapper (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  dd_loader_pkg::dl_addr_t    ioctl_addr,
    input  dd_loader_pkg::byte_t       ioctl_data,
    input  logic                       ioctl_wr,
    input  logic                       sdram_ack,
    output dd_loader_pkg::dl_addr_t    prog_addr,
    output dd_loader_pkg::byte_t       prog_data,
    output dd_loader_pkg::word_mask_t  prog_mask,
    output logic                       prog_we,
    output dd_loader_pkg::prom_we_t    prom_we,
    output dd_loader_pkg::prom_addr_t  prom_wr_addr,
    output dd_loader_pkg::byte_t       prom_wr_data
);

    dd_loader_pkg::dl_addr_t    map_addr;
    dd_loader_pkg::word_mask_t  map_mask;
    dd_loader_pkg::word_mask_t  mask8;
    dd_loader_pkg::prom_sel_t   prom_sel;
    logic                       is_prom;
    logic                       scr_top;
    logic                       obj_top;
    logic [4:0]                 scr_idx;   // 64K block inside the scroll half
    logic [4:0]                 obj_idx;   // 64K block inside the object half
    logic                       set_strobe;

    // Odd byte goes to the high half
    assign mask8 = {~ioctl_addr[0], ioctl_addr[0]};

    assign scr_top = ioctl_addr >= dd_loader_pkg::scr_xy_base;
    assign obj_top = ioctl_addr >= dd_loader_pkg::obj_xy_base;

    assign scr_idx = scr_top ? ioctl_addr[20:16] - dd_loader_pkg::scr_xy_base[20:16]
                             : ioctl_addr[20:16] - dd_loader_pkg::scr_zw_base[20:16];
    assign obj_idx = obj_top ? ioctl_addr[20:16] - dd_loader_pkg::obj_xy_base[20:16]
                             : ioctl_addr[20:16] - dd_loader_pkg::obj_wz_base[20:16];

    // Region decode, ordered by base address
    always_comb begin
        is_prom  = 1'b0;
        map_addr = {1'b0, ioctl_addr[21:1]};
        map_mask = mask8;
        if (ioctl_addr[21:16] < dd_loader_pkg::char_base[21:16]) begin
            // Main, sound and ADPCM keep the linear layout
            map_addr = {1'b0, ioctl_addr[21:1]};
            map_mask = mask8;
        end else if (ioctl_addr[21:16] < dd_loader_pkg::scr_zw_base[21:16]) begin
            // Character tiles, bit 3 picks the plane pair
            map_addr = {1'b0, ioctl_addr[21:5], ioctl_addr[2:0], ioctl_addr[4]};
            map_mask = {~ioctl_addr[3], ioctl_addr[3]};
        end else if (ioctl_addr[21:16] < dd_loader_pkg::obj_wz_base[21:16]) begin
            map_mask = scr_top ? 2'b01 : 2'b10;   // XY planes in the high byte
            map_addr = {1'b0, dd_loader_pkg::scr_bank + scr_idx,
                        ioctl_addr[15:6], ioctl_addr[3:0], ioctl_addr[5:4]};
        end else if (ioctl_addr[21:16] < dd_loader_pkg::mcu_base[21:16]) begin
            map_mask = obj_top ? 2'b01 : 2'b10;
            map_addr = {1'b0, dd_loader_pkg::obj_bank + obj_idx,
                        ioctl_addr[15:6], ioctl_addr[3:0], ioctl_addr[5:4]};
        end else if (ioctl_addr[21:12] < dd_loader_pkg::prom_base[21:12]) begin
            // MCU code, small enough to OR into the base
            map_addr = dd_loader_pkg::mcu_word_base | {9'd0, ioctl_addr[13:1]};
            map_mask = mask8;
        end else begin
            is_prom  = 1'b1;
            map_mask = 2'b11;   // Nothing goes to SDRAM
        end
    end

    // SDRAM request, held until the writer acknowledges it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (ioctl_wr && !is_prom) begin
            prog_we <= 1'b1;
        end else if (sdram_ack || !downloading) begin
            prog_we <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr && !is_prom) begin
            prog_addr <= map_addr;
            prog_data <= ioctl_data;
            prog_mask <= map_mask;
        end
    end

    // PROM byte is latched first, the bank pulse follows a cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            set_strobe <= 1'b0;
            prom_we    <= '0;
        end else begin
            set_strobe <= ioctl_wr && is_prom;
            if (set_strobe) begin
                prom_we <= dd_loader_pkg::prom_we_t'(1) << prom_sel;
            end else begin
                prom_we <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr && is_prom) begin
            prom_sel     <= ioctl_addr[9:8];
            prom_wr_addr <= ioctl_addr[7:0];
            prom_wr_data <= ioctl_data;
        end
    end

endmodule

//--- source/dd_prom_bank.sv
// ======================================================================
// One 256-byte on-chip PROM
// Synchronous write port and registered read port
// ======================================================================

`timescale 1ns/1ns

module dd_prom_bank (
    input  logic                       clk,
    input  logic                       we,
    input  dd_loader_pkg::prom_addr_t  wr_addr,
    input  dd_loader_pkg::byte_t       wr_data,
    input  dd_loader_pkg::prom_addr_t  rd_addr,
    output dd_loader_pkg::byte_t       rd_data
);

    dd_loader_pkg::byte_t mem [256];

    // Block RAM comes up cleared on the FPGA
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];   // One cycle read latency
    end

endmodule

//--- source/dd_prom_reader.sv
// ======================================================================
// PROM read-back
// Picks one bank's read data and registers it for the rest of the core
// ======================================================================

`timescale 1ns/1ns

module dd_prom_reader (
    input  logic                      clk,
    input  logic                      rst_n,
    input  dd_loader_pkg::prom_sel_t  rd_sel,
    input  dd_loader_pkg::byte_t      bank_data [dd_loader_pkg::prom_count],
    output dd_loader_pkg::byte_t      prom_rd_data
);

    dd_loader_pkg::prom_sel_t sel_q;   // Aligned with the bank read register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else begin
            sel_q <= rd_sel;
        end
    end

    // Second stage of the two-cycle read path
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prom_rd_data <= '0;
        end else begin
            prom_rd_data <= bank_data[sel_q];
        end
    end

endmodule

//--- source/dd_sdram_writer.sv
// ======================================================================
// SDRAM programming port
// Holds one masked byte write until the memory is ready
// Returns a single-cycle acknowledge to the mapper
// ======================================================================

`timescale 1ns/1ns

module dd_sdram_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  dd_loader_pkg::dl_addr_t    prog_addr,
    input  dd_loader_pkg::byte_t       prog_data,
    input  dd_loader_pkg::word_mask_t  prog_mask,
    input  logic                       prog_we,
    input  logic                       sdram_rdy,
    output dd_loader_pkg::dl_addr_t    sdram_addr,
    output logic [15:0]                sdram_din,
    output dd_loader_pkg::word_mask_t  sdram_dqm,
    output logic                       sdram_wr,
    output logic                       sdram_ack
);

    dd_loader_pkg::wr_state_t state;
    logic                     take;

    // New request accepted only from idle
    assign take = (state == dd_loader_pkg::idle) && prog_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= dd_loader_pkg::idle;
            sdram_wr  <= 1'b0;
            sdram_ack <= 1'b0;
        end else begin
            sdram_ack <= 1'b0;
            case (state)
                dd_loader_pkg::idle: begin
                    if (prog_we) begin
                        sdram_wr <= 1'b1;
                        state    <= dd_loader_pkg::write;
                    end
                end
                dd_loader_pkg::write: begin
                    if (sdram_rdy) begin   // Accepted this cycle
                        sdram_wr  <= 1'b0;
                        sdram_ack <= 1'b1;
                        state     <= dd_loader_pkg::ack;
                    end
                end
                dd_loader_pkg::ack: begin
                    // Wait for the mapper to drop the request
                    if (!prog_we) begin
                        state <= dd_loader_pkg::idle;
                    end
                end
                default: begin
                    sdram_wr <= 1'b0;
                    state    <= dd_loader_pkg::idle;
                end
            endcase
        end
    end

    // Request payload, stable while sdram_wr is high
    always_ff @(posedge clk) begin
        if (take) begin
            sdram_addr <= prog_addr;
            sdram_din  <= {prog_data, prog_data};   // Byte on both halves
            sdram_dqm  <= prog_mask;
        end
    end

endmodule

//--- source/dd_rom_loader.sv
// ======================================================================
// ROM download path top level
// Mapper, SDRAM writer, PROM bank row and PROM read-back
// ======================================================================

`timescale 1ns/1ns

module dd_rom_loader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  dd_loader_pkg::dl_addr_t    ioctl_addr,
    input  dd_loader_pkg::byte_t       ioctl_data,
    input  logic                       ioctl_wr,
    output dd_loader_pkg::dl_addr_t    sdram_addr,
    output logic [15:0]                sdram_din,
    output dd_loader_pkg::word_mask_t  sdram_dqm,
    output logic                       sdram_wr,
    input  logic                       sdram_rdy,
    input  dd_loader_pkg::prom_sel_t   prom_rd_sel,
    input  dd_loader_pkg::prom_addr_t  prom_rd_addr,
    output dd_loader_pkg::byte_t       prom_rd_data
);

    dd_loader_pkg::dl_addr_t    prog_addr;
    dd_loader_pkg::byte_t       prog_data;
    dd_loader_pkg::word_mask_t  prog_mask;
    logic                       prog_we;
    logic                       sdram_ack;
    dd_loader_pkg::prom_we_t    prom_we;
    dd_loader_pkg::prom_addr_t  prom_wr_addr;
    dd_loader_pkg::byte_t       prom_wr_data;
    dd_loader_pkg::byte_t       bank_rd_data [dd_loader_pkg::prom_count];

    dd_rom_mapper u_mapper (
        .clk          (clk),
        .rst_n        (rst_n),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .sdram_ack    (sdram_ack),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_mask    (prog_mask),
        .prog_we      (prog_we),
        .prom_we      (prom_we),
        .prom_wr_addr (prom_wr_addr),
        .prom_wr_data (prom_wr_data)
    );

    dd_sdram_writer u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_mask  (prog_mask),
        .prog_we    (prog_we),
        .sdram_rdy  (sdram_rdy),
        .sdram_addr (sdram_addr),
        .sdram_din  (sdram_din),
        .sdram_dqm  (sdram_dqm),
        .sdram_wr   (sdram_wr),
        .sdram_ack  (sdram_ack)
    );

    // Row of PROMs, each with its own write enable and a shared read address
    for (genvar i = 0; i < dd_loader_pkg::prom_count; i++) begin : g_prom
        dd_prom_bank u_bank (
            .clk     (clk),
            .we      (prom_we[i]),
            .wr_addr (prom_wr_addr),
            .wr_data (prom_wr_data),
            .rd_addr (prom_rd_addr),
            .rd_data (bank_rd_data[i])
        );
    end

    dd_prom_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_sel       (prom_rd_sel),
        .bank_data    (bank_rd_data),
        .prom_rd_data (prom_rd_data)
    );

endmodule

//--- bench/tb_clock.sv
// ======================================================================
// Testbench clock and reset
// 10 ns clock, reset held low for the first 3 cycles
// ======================================================================

`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;   // Released off the edge like other stimulus
    end

endmodule

//--- bench/tb_sdram_model.sv
// ======================================================================
// SDRAM stand-in for the testbench
// Random 0 to 3 cycle ready delay from an xorshift generator
// Sparse 16-bit word store honouring the active-low byte mask
// ======================================================================

`timescale 1ns/1ns

module tb_sdram_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,      // Holds ready low while set
    input  logic [21:0] sdram_addr,
    input  logic [15:0] sdram_din,
    input  logic [1:0]  sdram_dqm,
    input  logic        sdram_wr,
    output logic        sdram_rdy,
    output logic [15:0] old_word,   // Word before the last write
    output logic [15:0] new_word    // Word after the last write
);

    logic [15:0] mem [logic [21:0]];
    logic [31:0] rng;
    logic [1:0]  wait_cnt;
    logic        busy;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(posedge clk) begin : store
        logic [15:0] cur;
        if (!rst_n) begin
            sdram_rdy <= 1'b0;
            busy      <= 1'b0;
            wait_cnt  <= 2'd0;
            rng       <= 32'hdecf;
        end else if (sdram_wr && sdram_rdy) begin
            // Unwritten words read back a pattern of their address
            if (mem.exists(sdram_addr)) begin
                cur = mem[sdram_addr];
            end else begin
                cur = sdram_addr[15:0] ^ {10'd0, sdram_addr[21:16]};
            end
            old_word <= cur;
            cur = {sdram_dqm[1] ? cur[15:8] : sdram_din[15:8],
                   sdram_dqm[0] ? cur[7:0]  : sdram_din[7:0]};
            mem[sdram_addr] = cur;
            new_word  <= cur;
            sdram_rdy <= 1'b0;
            busy      <= 1'b0;
        end else if (sdram_wr && !busy) begin
            busy     <= 1'b1;
            wait_cnt <= rng[1:0];   // New delay per request
            rng      <= xorshift(rng);
        end else if (busy && !stall) begin
            if (wait_cnt == 2'd0) begin
                sdram_rdy <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

//--- bench/tb_dd_rom_loader.sv
// ======================================================================
// Testbench of the ROM download path
// Table of download bytes applied in a loop, SDRAM and PROM checks
// Stalled write with the download ending, watchdog
// ======================================================================

`timescale 1ns/1ns

module tb_dd_rom_loader;

    localparam int n_entries       = 20;
    localparam int watchdog_cycles = n_entries * 20 + 200;

    // Address in bits 29:8 and data in bits 7:0
    localparam logic [29:0] stim [n_entries] = '{
        {22'h000001, 8'hA5}, {22'h000000, 8'h5A},   // Both halves of word 0
        {22'h012344, 8'h3C}, {22'h030007, 8'h81},   // Main, ADPCM
        {22'h050018, 8'hC7}, {22'h05002D, 8'h2E},   // Character
        {22'h060073, 8'h11}, {22'h07ABCD, 8'h9B},   // Scroll lower half
        {22'h080015, 8'hE4}, {22'h09F0F0, 8'h76},   // Scroll upper half
        {22'h0A1234, 8'hD2}, {22'h0D0001, 8'h4F},   // Object lower half
        {22'h0E4321, 8'hB8}, {22'h11FFFF, 8'h0C},   // Object upper half
        {22'h120003, 8'h6D}, {22'h123FFE, 8'hF1},   // MCU
        {22'h124005, 8'h12}, {22'h124155, 8'h34},   // PROM banks 0 and 1
        {22'h1242AA, 8'h56}, {22'h1243FF, 8'h78}    // PROM banks 2 and 3
    };

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic [21:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic [21:0] sdram_addr;
    logic [15:0] sdram_din;
    logic [1:0]  sdram_dqm;
    logic        sdram_wr;
    logic        sdram_rdy;
    logic [1:0]  prom_rd_sel;
    logic [7:0]  prom_rd_addr;
    logic [7:0]  prom_rd_data;
    logic        stall;
    logic [15:0] old_word;
    logic [15:0] new_word;
    logic [7:0]  prom_exp [4][256];
    logic [7:0]  last_read;
    logic [21:0] hs_addr;
    logic [15:0] hs_din;
    logic [1:0]  hs_dqm;
    int          wr_count;
    int          checks;
    int          check_errors;
    int          other_errors;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    tb_sdram_model u_sdram (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .sdram_addr(sdram_addr), .sdram_din(sdram_din), .sdram_dqm(sdram_dqm),
        .sdram_wr(sdram_wr), .sdram_rdy(sdram_rdy),
        .old_word(old_word), .new_word(new_word)
    );

    dd_rom_loader dut (
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .sdram_addr(sdram_addr), .sdram_din(sdram_din), .sdram_dqm(sdram_dqm),
        .sdram_wr(sdram_wr), .sdram_rdy(sdram_rdy),
        .prom_rd_sel(prom_rd_sel), .prom_rd_addr(prom_rd_addr),
        .prom_rd_data(prom_rd_data)
    );

    // Every accepted SDRAM write and its payload
    always @(posedge clk) begin
        if (!rst_n) begin
            wr_count <= 0;
        end else if (sdram_wr && sdram_rdy) begin
            wr_count <= wr_count + 1;
            hs_addr  <= sdram_addr;
            hs_din   <= sdram_din;
            hs_dqm   <= sdram_dqm;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [21:0] a, input logic [7:0] d);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        tick(1);
        ioctl_wr = 1'b0;
    endtask

    task automatic wait_prog_idle();
        int n;
        n = 0;
        while (dut.prog_we && n < 20) begin
            tick(1);
            n++;
        end
        if (dut.prog_we) begin
            other_errors++;
            $display("SDRAM request at %0t ns was never acknowledged", $time);
        end
    endtask

    // Read one PROM byte and check the two-cycle read latency
    task automatic read_prom(input logic [1:0] sel, input logic [7:0] addr);
        prom_rd_sel  = sel;
        prom_rd_addr = addr;
        tick(1);
        check("prom_rd_data (1 cycle)", 32'(prom_rd_data), 32'(last_read));
        tick(1);
        last_read = prom_exp[sel][addr];
        check("prom_rd_data", 32'(prom_rd_data), 32'(last_read));
    endtask

    // Word address in bits 21:0 and active-low mask in bits 23:22
    function automatic logic [23:0] expect_map(input logic [21:0] a);
        logic [21:0] half_base;
        logic [4:0]  blk;
        logic [21:0] w;
        logic [1:0]  m;
        w = {1'b0, a[21:1]};
        m = a[0] ? 2'b01 : 2'b10;   // Odd bytes land high
        if (a >= dd_loader_pkg::mcu_base) begin
            w = 22'h018000 + {9'd0, a[13:1]};
        end else if (a >= dd_loader_pkg::obj_wz_base) begin
            half_base = (a >= dd_loader_pkg::obj_xy_base) ? dd_loader_pkg::obj_xy_base
                                                          : dd_loader_pkg::obj_wz_base;
            blk = dd_loader_pkg::obj_bank + 5'((a - half_base) >> 16);
            w   = {1'b0, blk, a[15:6], a[3:0], a[5:4]};
            m   = (a >= dd_loader_pkg::obj_xy_base) ? 2'b01 : 2'b10;
        end else if (a >= dd_loader_pkg::scr_zw_base) begin
            half_base = (a >= dd_loader_pkg::scr_xy_base) ? dd_loader_pkg::scr_xy_base
                                                          : dd_loader_pkg::scr_zw_base;
            blk = dd_loader_pkg::scr_bank + 5'((a - half_base) >> 16);
            w   = {1'b0, blk, a[15:6], a[3:0], a[5:4]};
            m   = (a >= dd_loader_pkg::scr_xy_base) ? 2'b01 : 2'b10;
        end else if (a >= dd_loader_pkg::char_base) begin
            w = {1'b0, a[21:5], a[2:0], a[4]};
            m = a[3] ? 2'b01 : 2'b10;
        end
        return {m, w};
    endfunction

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [23:0] m;
        logic [21:0] a;
        logic [7:0]  d;
        int          base_count;
        int          n;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        prom_rd_sel  = '0;
        prom_rd_addr = '0;
        stall        = 1'b0;
        last_read    = '0;
        checks       = 0;
        check_errors = 0;
        other_errors = 0;
        for (int b = 0; b < 4; b++) begin
            for (int i = 0; i < 256; i++) begin
                prom_exp[b][i] = '0;
            end
        end
        wait (rst_n);
        tick(1);
        repeat (4) begin   // Quiet after reset
            check("sdram_wr", 32'(sdram_wr), 0);
            check("prom_rd_data", 32'(prom_rd_data), 0);
            tick(1);
        end
        downloading = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            a = stim[i][29:8];
            d = stim[i][7:0];
            base_count = wr_count;
            send_byte(a, d);
            if (a >= dd_loader_pkg::prom_base) begin
                prom_exp[a[9:8]][a[7:0]] = d;
                tick(4);
                check("sdram writes", wr_count, base_count);
                check("sdram_wr", 32'(sdram_wr), 0);
            end else begin
                m = expect_map(a);
                wait_prog_idle();
                check("sdram writes", wr_count, base_count + 1);
                check("sdram_addr", 32'(hs_addr), 32'(m[21:0]));
                check("sdram_dqm", 32'(hs_dqm), 32'(m[23:22]));
                check("sdram_din", 32'(hs_din), 32'({d, d}));
                check("stored word", 32'(new_word),
                      32'({m[23] ? old_word[15:8] : d, m[22] ? old_word[7:0] : d}));
            end
        end
        // Every bank at every written PROM address
        for (int i = 0; i < n_entries; i++) begin
            a = stim[i][29:8];
            if (a >= dd_loader_pkg::prom_base) begin
                for (int b = 0; b < 4; b++) begin
                    read_prom(2'(b), a[7:0]);
                end
            end
        end
        // Stalled write with the download ending underneath it
        stall = 1'b1;
        base_count = wr_count;
        send_byte(22'h000101, 8'hC3);
        tick(2);
        check("sdram_wr", 32'(sdram_wr), 1);
        downloading = 1'b0;
        tick(2);
        check("prog_we", 32'(dut.prog_we), 0);
        check("sdram writes", wr_count, base_count);
        stall = 1'b0;
        n = 0;
        while (wr_count == base_count && n < 20) begin
            tick(1);
            n++;
        end
        tick(6);
        check("sdram writes", wr_count, base_count + 1);
        check("sdram_wr", 32'(sdram_wr), 0);
        $display("Checks run: %0d, failed: %0d, other errors: %0d",
                 checks, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
source/dd_loader_pkg.sv
source/dd_rom_mapper.sv
source/dd_prom_bank.sv
source/dd_prom_reader.sv
source/dd_sdram_writer.sv
source/dd_rom_loader.sv
bench/tb_clock.sv
bench/tb_sdram_model.sv
bench/tb_dd_rom_loader.sv

//--- Makefile
# Verilator build and run of the ROM download path testbench

VERILATOR ?= verilator
TOP       ?= tb_dd_rom_loader
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; \
	    exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
